// ==== design/sifhPkg.sv ====
package sifhPkg;

    // default geometry, each module gets it passed down from the top
    localparam int defTsBits    = 10;  // tdc timestamp width
    localparam int defBinBits   = 4;   // 16 bins, top bits of the timestamp
    localparam int defPixBits   = 2;   // 4 pixels share one ram
    localparam int defCountBits = 8;   // bin counter, sticks at all ones
    localparam int defFrameBits = 12;  // width of the events per frame input

    // frame sequence, one pass per frame
    // clear -> accumulate -> scan -> clear ...
    typedef enum logic [1:0] {
        phClear,  // zero every word of the count ram
        phAccum,  // bin increments from incoming events
        phScan    // peak search, one result per pixel
    } framePhaseT;

endpackage

// ==== design/histRam.sv ====
module histRam #(
    parameter int PixBits   = sifhPkg::defPixBits,
    parameter int BinBits   = sifhPkg::defBinBits,
    parameter int CountBits = sifhPkg::defCountBits
) (
    input  logic                       clk,
    input  logic                       wrEn,
    input  logic [PixBits+BinBits-1:0] wrAddr,
    input  logic [CountBits-1:0]       wrData,
    input  logic [PixBits+BinBits-1:0] rdAddrA,   // accumulator side
    output logic [CountBits-1:0]       rdDataA,
    input  logic [PixBits+BinBits-1:0] rdAddrB,   // scanner side
    output logic [CountBits-1:0]       rdDataB
);

    // one word per pixel and bin, pixel in the upper address bits
    localparam int Depth = (1 << PixBits) * (1 << BinBits);

    logic [CountBits-1:0] mem [Depth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
        // read before write: same word in one cycle gives the old count
        rdDataA <= mem[rdAddrA];
        rdDataB <= mem[rdAddrB];
    end

endmodule

// ==== design/binMapper.sv ====
module binMapper #(
    parameter int TsBits  = sifhPkg::defTsBits,
    parameter int BinBits = sifhPkg::defBinBits,
    parameter int PixBits = sifhPkg::defPixBits
) (
    input  logic                       clk,
    input  logic                       res,
    input  logic                       evtValid,
    output logic                       evtReady,
    input  logic [PixBits-1:0]         evtPixel,
    input  logic [TsBits-1:0]          evtTime,
    output logic                       mapValid,
    input  logic                       mapReady,
    output logic [PixBits+BinBits-1:0] mapAddr
);

    logic full;  // stage register holds an event
    logic take;  // event transfer this cycle

    // fill only while the accumulator is open
    // keeps events out during clear and scan
    assign evtReady = mapReady;
    assign take     = evtValid && evtReady;
    assign mapValid = full;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            full <= 1'b0;
        end else if (mapReady) begin  // old word leaves, a new one may enter
            full <= evtValid;
        end
    end

    // bin = coarse part of the timestamp, placed under the pixel index
    always_ff @(posedge clk) begin
        if (take) begin
            mapAddr <= {evtPixel, evtTime[TsBits-1 -: BinBits]};
        end
    end

    // held word must not move until the accumulator takes it
    mapHold: assert property (@(posedge clk) disable iff (!res)
        mapValid && !mapReady |=> $stable(mapAddr));

endmodule

// ==== design/histAccumulator.sv ====
module histAccumulator #(
    parameter int PixBits   = sifhPkg::defPixBits,
    parameter int BinBits   = sifhPkg::defBinBits,
    parameter int CountBits = sifhPkg::defCountBits
) (
    input  logic                       clk,
    input  logic                       res,
    input  sifhPkg::framePhaseT        phase,
    input  logic                       accOpen,
    input  logic                       mapValid,
    output logic                       mapReady,
    input  logic [PixBits+BinBits-1:0] mapAddr,
    output logic [PixBits+BinBits-1:0] rdAddrA,
    input  logic [CountBits-1:0]       rdDataA,
    output logic                       wrEn,
    output logic [PixBits+BinBits-1:0] wrAddr,
    output logic [CountBits-1:0]       wrData,
    output logic                       accTaken,
    output logic                       accIdle,
    output logic                       clearDone
);

    import sifhPkg::*;

    localparam int AddrBits = PixBits + BinBits;
    localparam int Depth    = (1 << PixBits) * (1 << BinBits);  // pixels times bins

    logic                 clrActive;  // sweep owns the write port
    logic [AddrBits-1:0]  clrAddr;
    logic                 s1Valid;    // read went out last cycle, data on rdDataA now
    logic [AddrBits-1:0]  s1Addr;
    logic                 lastValid;  // word written in the previous cycle
    logic [AddrBits-1:0]  lastAddr;
    logic [CountBits-1:0] lastData;
    logic [CountBits-1:0] base;       // count before this increment
    logic [CountBits-1:0] incVal;

    assign mapReady = (phase == phAccum) && accOpen;
    assign accTaken = mapValid && mapReady;
    assign accIdle  = !s1Valid;
    assign rdAddrA  = mapAddr;  // read goes out in the accept cycle

    // ram returned the old word if the previous increment landed on the same edge
    assign base   = (lastValid && lastAddr == s1Addr) ? lastData : rdDataA;
    assign incVal = (base == '1) ? base : base + 1'b1;  // saturating add

    // sweep and increments never overlap, phases differ
    assign wrEn   = clrActive || s1Valid;
    assign wrAddr = clrActive ? clrAddr : s1Addr;
    assign wrData = clrActive ? '0 : incVal;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clrActive <= 1'b0;
            clrAddr   <= '0;
            clearDone <= 1'b0;
            s1Valid   <= 1'b0;
            lastValid <= 1'b0;
        end else begin
            clearDone <= 1'b0;
            s1Valid   <= accTaken;
            lastValid <= s1Valid;
            if (clrActive) begin
                if (clrAddr == AddrBits'(Depth - 1)) begin
                    clrActive <= 1'b0;
                    clearDone <= 1'b1;  // one pulse, ctrl moves to accumulate
                end
                clrAddr <= clrAddr + 1'b1;  // wraps back to word 0
            end else if (phase == phClear && !clearDone) begin
                clrActive <= 1'b1;  // first clock after reset or scan
                clrAddr   <= '0;
            end
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        s1Addr   <= mapAddr;
        lastAddr <= s1Addr;
        lastData <= incVal;
    end

    // ram is frozen while the scanner reads it
    noScanWrite: assert property (@(posedge clk) disable iff (!res)
        phase == phScan |-> !wrEn);

    // a full bin stays full across back-to-back hits
    satHold: assert property (@(posedge clk) disable iff (!res)
        phase == phAccum && wrEn && $past(wrEn) && $past(wrData) == '1
            && $past(wrAddr) == wrAddr |-> wrData == '1);

endmodule

// ==== design/peakScanner.sv ====
module peakScanner #(
    parameter int PixBits   = sifhPkg::defPixBits,
    parameter int BinBits   = sifhPkg::defBinBits,
    parameter int CountBits = sifhPkg::defCountBits
) (
    input  logic                       clk,
    input  logic                       res,
    input  sifhPkg::framePhaseT        phase,
    output logic [PixBits+BinBits-1:0] rdAddrB,
    input  logic [CountBits-1:0]       rdDataB,
    output logic                       resValid,
    input  logic                       resReady,
    output logic [PixBits-1:0]         resPixel,
    output logic [BinBits-1:0]         resBin,
    output logic [CountBits-1:0]       resCount,
    output logic                       scanDone
);

    import sifhPkg::*;

    logic                 inScan;   // this frame's scan under way
    logic                 issuing;  // bin reads still going out for pixQ
    logic [PixBits-1:0]   pixQ;
    logic [BinBits-1:0]   binQ;
    logic                 rdValid;  // rdDataB belongs to rdBin
    logic                 rdLast;   // ... and rdBin is the last bin
    logic [BinBits-1:0]   rdBin;
    logic [CountBits-1:0] peakCount;
    logic [BinBits-1:0]   peakBin;
    logic                 better;

    assign rdAddrB  = {pixQ, binQ};
    assign resPixel = pixQ;  // pixel moves on only after the result is taken
    // bin 0 seeds the peak, later bins have to beat it strictly
    assign better   = (rdBin == '0) || (rdDataB > peakCount);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            inScan   <= 1'b0;
            issuing  <= 1'b0;
            pixQ     <= '0;
            binQ     <= '0;
            rdValid  <= 1'b0;
            rdLast   <= 1'b0;
            resValid <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            scanDone <= 1'b0;
            rdValid  <= issuing;
            rdLast   <= issuing && binQ == '1;
            if (phase != phScan) begin
                inScan <= 1'b0;
            end else if (!inScan) begin  // entry into scan
                inScan  <= 1'b1;
                issuing <= 1'b1;
                pixQ    <= '0;
                binQ    <= '0;
            end
            if (issuing) begin
                issuing <= (binQ != '1);
                binQ    <= binQ + 1'b1;  // back to bin 0 after the last
            end
            if (rdLast) begin
                resValid <= 1'b1;
            end
            if (resValid && resReady) begin
                resValid <= 1'b0;
                if (pixQ == '1) begin
                    scanDone <= 1'b1;  // last pixel out, ctrl goes to clear
                end else begin
                    pixQ    <= pixQ + 1'b1;
                    issuing <= 1'b1;
                end
            end
        end
    end

    // running max, one cycle behind the address
    always_ff @(posedge clk) begin
        rdBin <= binQ;
        if (rdValid && better) begin
            peakCount <= rdDataB;
            peakBin   <= rdBin;
        end
        if (rdLast) begin
            resBin   <= better ? rdBin : peakBin;
            resCount <= better ? rdDataB : peakCount;
        end
    end

    resHold: assert property (@(posedge clk) disable iff (!res)
        resValid && !resReady |=> resValid && $stable({resPixel, resBin, resCount}));

endmodule

// ==== design/histFrameCtrl.sv ====
module histFrameCtrl #(
    parameter int FrameBits = sifhPkg::defFrameBits
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic [FrameBits-1:0] frameLen,
    input  logic                 accTaken,
    input  logic                 accIdle,
    input  logic                 clearDone,
    input  logic                 scanDone,
    output sifhPkg::framePhaseT  phase,
    output logic                 accOpen
);

    import sifhPkg::*;

    logic [FrameBits-1:0] lenQ;      // frame length sampled at accumulate entry
    logic [FrameBits-1:0] takenCnt;  // events accepted in this frame

    // accumulator stays open until the frame is full
    assign accOpen = takenCnt < lenQ;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            phase    <= phClear;  // ram content unknown after reset
            lenQ     <= '0;
            takenCnt <= '0;
        end else begin
            case (phase)
                phClear: begin
                    if (clearDone) begin
                        phase    <= phAccum;
                        lenQ     <= frameLen;
                        takenCnt <= '0;
                    end
                end
                phAccum: begin
                    if (accTaken) begin
                        takenCnt <= takenCnt + 1'b1;
                    end
                    // last increment must have landed before the scan reads
                    if (!accOpen && accIdle) begin
                        phase <= phScan;
                    end
                end
                phScan: begin
                    if (scanDone) begin
                        phase <= phClear;  // next frame
                    end
                end
                default: phase <= phClear;
            endcase
        end
    end

    // no event slips past the frame length
    frameBound: assert property (@(posedge clk) disable iff (!res)
        takenCnt <= lenQ);

endmodule

// ==== design/sifhTop.sv ====
module sifhTop #(
    parameter int TsBits    = sifhPkg::defTsBits,
    parameter int BinBits   = sifhPkg::defBinBits,
    parameter int PixBits   = sifhPkg::defPixBits,
    parameter int CountBits = sifhPkg::defCountBits,
    parameter int FrameBits = sifhPkg::defFrameBits
) (
    input  logic                 clk,
    input  logic                 res,
    input  logic                 evtValid,
    output logic                 evtReady,
    input  logic [PixBits-1:0]   evtPixel,
    input  logic [TsBits-1:0]    evtTime,
    input  logic [FrameBits-1:0] frameLen,
    output logic                 resValid,
    input  logic                 resReady,
    output logic [PixBits-1:0]   resPixel,
    output logic [BinBits-1:0]   resBin,
    output logic [CountBits-1:0] resCount
);

    import sifhPkg::*;

    framePhaseT                 phase;
    logic                       accOpen;
    logic                       mapValid;
    logic                       mapReady;
    logic [PixBits+BinBits-1:0] mapAddr;
    logic                       accTaken;
    logic                       accIdle;
    logic                       clearDone;
    logic                       scanDone;
    logic                       wrEn;
    logic [PixBits+BinBits-1:0] wrAddr;    // ram write port, accumulator
    logic [CountBits-1:0]       wrData;
    logic [PixBits+BinBits-1:0] rdAddrA;   // read port A, accumulator
    logic [CountBits-1:0]       rdDataA;
    logic [PixBits+BinBits-1:0] rdAddrB;   // read port B, scanner
    logic [CountBits-1:0]       rdDataB;

    binMapper #(.TsBits(TsBits), .BinBits(BinBits), .PixBits(PixBits)) mapper0 (
        .clk(clk), .res(res), .evtValid(evtValid), .evtReady(evtReady),
        .evtPixel(evtPixel), .evtTime(evtTime),
        .mapValid(mapValid), .mapReady(mapReady), .mapAddr(mapAddr));

    histAccumulator #(.PixBits(PixBits), .BinBits(BinBits), .CountBits(CountBits)) acc0 (
        .clk(clk), .res(res), .phase(phase), .accOpen(accOpen),
        .mapValid(mapValid), .mapReady(mapReady), .mapAddr(mapAddr),
        .rdAddrA(rdAddrA), .rdDataA(rdDataA),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .accTaken(accTaken), .accIdle(accIdle), .clearDone(clearDone));

    peakScanner #(.PixBits(PixBits), .BinBits(BinBits), .CountBits(CountBits)) scan0 (
        .clk(clk), .res(res), .phase(phase), .rdAddrB(rdAddrB), .rdDataB(rdDataB),
        .resValid(resValid), .resReady(resReady), .resPixel(resPixel),
        .resBin(resBin), .resCount(resCount), .scanDone(scanDone));

    histFrameCtrl #(.FrameBits(FrameBits)) ctrl0 (
        .clk(clk), .res(res), .frameLen(frameLen),
        .accTaken(accTaken), .accIdle(accIdle), .clearDone(clearDone),
        .scanDone(scanDone), .phase(phase), .accOpen(accOpen));

    histRam #(.PixBits(PixBits), .BinBits(BinBits), .CountBits(CountBits)) ram0 (
        .clk(clk), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .rdAddrA(rdAddrA), .rdDataA(rdDataA), .rdAddrB(rdAddrB), .rdDataB(rdDataB));

endmodule

// ==== tb/sifhTb.sv ====
module sifhTb;

    import sifhPkg::*;

    localparam int TsBits      = defTsBits;
    localparam int BinBits     = defBinBits;
    localparam int PixBits     = defPixBits;
    localparam int CountBits   = defCountBits;
    localparam int FrameBits   = defFrameBits;
    localparam int NumPix      = 1 << PixBits;
    localparam int NumBins     = 1 << BinBits;
    localparam int Depth       = NumPix * NumBins;
    localparam int CountMax    = (1 << CountBits) - 1;  // saturation level
    localparam int NumFrames   = 4;
    localparam int ResetCycles = 10;
    localparam logic [31:0] SeedInit = 32'hc0c7_ce67;

    // one bin and count per pixel, count in the low bits
    typedef logic [NumPix-1:0][BinBits+CountBits-1:0] peakVecT;

    logic                 clk;
    logic                 res;
    logic                 evtValid;
    logic                 evtReady;
    logic [PixBits-1:0]   evtPixel;
    logic [TsBits-1:0]    evtTime;
    logic [FrameBits-1:0] frameLen;
    logic                 resValid;
    logic                 resReady;
    logic [PixBits-1:0]   resPixel;
    logic [BinBits-1:0]   resBin;
    logic [CountBits-1:0] resCount;

    logic [PixBits+TsBits-1:0] evtQ [$];  // events of the current frame, {pixel, time}
    peakVecT              expPeaks;
    logic [31:0]          evtSeed = SeedInit;
    logic [31:0]          rdySeed = SeedInit;
    logic [31:0]          rdyRnd;
    logic                 rdyNext;
    logic                 readyRandom = 1'b0;  // back-pressure on results
    int                   resultsSeen;
    int                   cycles;
    int                   limit;
    logic                 holdPending;  // result was stalled at the last negedge
    logic [PixBits-1:0]   heldPix;
    logic [BinBits-1:0]   heldBin;
    logic [CountBits-1:0] heldCount;

    sifhTop dut0 (
        .clk(clk), .res(res), .evtValid(evtValid), .evtReady(evtReady),
        .evtPixel(evtPixel), .evtTime(evtTime), .frameLen(frameLen),
        .resValid(resValid), .resReady(resReady), .resPixel(resPixel),
        .resBin(resBin), .resCount(resCount));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // events per frame: random, same-bin runs, saturating bin, random again
    function automatic int frameLength(input int f);
        case (f)
            0:       return 200;
            1:       return 48;
            2:       return 310;
            default: return 150;
        endcase
    endfunction

    // clear + events + scan of every frame, with slack for stalls
    function automatic int cycleBudget();
        int total;
        total = ResetCycles + Depth;
        for (int f = 0; f < NumFrames; f++) begin
            total += Depth + 2 + frameLength(f) + 2 + NumPix * (NumBins + 3);
        end
        return 4 * total;
    endfunction

    // histogram of evtQ with saturating bins, then strict-greater peak per pixel
    function automatic peakVecT refPeaks();
        int                 hist [NumPix][NumBins];
        int                 best;
        int                 bestBin;
        logic [PixBits-1:0] p;
        logic [BinBits-1:0] b;
        peakVecT            peaks;
        for (int q = 0; q < NumPix; q++) begin
            for (int k = 0; k < NumBins; k++) begin
                hist[q][k] = 0;
            end
        end
        foreach (evtQ[i]) begin
            p = evtQ[i][TsBits +: PixBits];
            b = evtQ[i][TsBits-1 -: BinBits];  // bin = coarse timestamp bits
            if (hist[p][b] < CountMax) begin
                hist[p][b]++;
            end
        end
        for (int q = 0; q < NumPix; q++) begin
            best    = hist[q][0];
            bestBin = 0;
            for (int k = 1; k < NumBins; k++) begin
                if (hist[q][k] > best) begin  // ties keep the lower bin
                    best    = hist[q][k];
                    bestBin = k;
                end
            end
            peaks[q] = {BinBits'(bestBin), CountBits'(best)};
        end
        return peaks;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("[ERROR] %s exp=%0h got=%0h", name, exp, got);
            $display("TESTS FAILED");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // called at posedge+2, returns at posedge+2 after the transfer
    task automatic sendEvent(input logic [PixBits-1:0] pix, input logic [TsBits-1:0] ts);
        evtValid = 1'b1;
        evtPixel = pix;
        evtTime  = ts;
        @(negedge clk);
        while (!evtReady) @(negedge clk);  // taken on the next rising edge
        evtQ.push_back({pix, ts});
        @(posedge clk);
        #2;
    endtask

    task automatic sendFrame(input int f);
        logic [31:0]        rnd;
        logic [PixBits-1:0] pix;
        logic [BinBits-1:0] bin;
        logic [TsBits-1:0]  ts;
        for (int i = 0; i < frameLength(f); i++) begin
            rnd = $random(evtSeed);
            ts  = rnd[TsBits-1:0];
            pix = rnd[TsBits +: PixBits];
            bin = '0;
            if (f == 1) begin  // back-to-back hits, then A/B alternation
                if (i < 16) begin
                    pix = PixBits'(1);
                    bin = BinBits'(5);
                end else if (i < 32) begin
                    pix = PixBits'(3);
                    bin = (i % 2 == 0) ? BinBits'(2) : BinBits'(7);  // tie, bin 2 wins
                end else begin
                    pix = PixBits'(0);
                    bin = BinBits'(15);
                end
                ts = {bin, rnd[TsBits-BinBits-1:0]};
            end else if (f == 2 && i < 300) begin  // one bin well past full
                pix = PixBits'(2);
                ts  = {BinBits'(9), rnd[TsBits-BinBits-1:0]};
            end else if (f == 2) begin
                pix = PixBits'(0);
            end
            sendEvent(pix, ts);
        end
        evtValid = 1'b0;
    endtask

    initial begin
        res      = 1'b0;
        evtValid = 1'b0;
        evtPixel = '0;
        evtTime  = '0;
        frameLen = FrameBits'(frameLength(0));
        repeat (ResetCycles) @(posedge clk);
        #2 res = 1'b1;
        // post-reset sweep, no events offered
        repeat (Depth) begin
            @(negedge clk);
            checkVal("evtReady", 32'(1'b0), 32'(evtReady));
            checkVal("resValid", 32'(1'b0), 32'(resValid));
        end
        while (!evtReady) @(negedge clk);  // opens by itself after the sweep
        @(posedge clk);
        #2;
        for (int f = 0; f < NumFrames; f++) begin
            evtQ.delete();
            readyRandom = (f >= 2);
            sendFrame(f);
            expPeaks = refPeaks();
            if (f + 1 < NumFrames) begin
                frameLen = FrameBits'(frameLength(f + 1));  // latched after next clear
            end
            while (resultsSeen < (f + 1) * NumPix) @(posedge clk);
            #2;
        end
        $display("TESTS PASSED");
        $finish;
    end

    // result back-pressure
    initial begin
        resReady = 1'b1;
        forever begin
            @(negedge clk);
            rdyRnd  = $random(rdySeed);
            rdyNext = readyRandom ? rdyRnd[0] : 1'b1;
            @(posedge clk);
            #2 resReady = rdyNext;
        end
    end

    // compare every result transfer, pixel order 0 upward
    initial begin
        resultsSeen = 0;
        holdPending = 1'b0;
        forever begin
            @(negedge clk);
            if (holdPending) begin  // stalled result must not move
                checkVal("resValid", 32'(1'b1), 32'(resValid));
                checkVal("resPixel", 32'(heldPix), 32'(resPixel));
                checkVal("resBin", 32'(heldBin), 32'(resBin));
                checkVal("resCount", 32'(heldCount), 32'(resCount));
            end
            holdPending = resValid && !resReady;
            heldPix     = resPixel;
            heldBin     = resBin;
            heldCount   = resCount;
            if (resValid && resReady) begin
                checkVal("resPixel", 32'(resultsSeen % NumPix), 32'(resPixel));
                checkVal("resBin", 32'(expPeaks[resultsSeen % NumPix][CountBits +: BinBits]),
                    32'(resBin));
                checkVal("resCount", 32'(expPeaks[resultsSeen % NumPix][CountBits-1:0]),
                    32'(resCount));
                resultsSeen++;
            end
        end
    end

    initial begin
        cycles = 0;
        limit  = cycleBudget();
        while (cycles <= limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("TESTS FAILED");
        $fatal(1, "timeout, not all results arrived within %0d cycles", limit);
    end

endmodule

// ==== src.f ====
design/sifhPkg.sv
design/histRam.sv
design/binMapper.sv
design/histAccumulator.sv
design/peakScanner.sv
design/histFrameCtrl.sv
design/sifhTop.sv
tb/sifhTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the histogram engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module sifhTb \
    -f src.f \
    -o sifhSim

./obj_dir/sifhSim
